/* common/ice_pkg.sv */
`default_nettype none

package ice_pkg;

	// One UART or bus byte
	typedef logic [7:0] ice_byte_t;

	// Host event id, echoed back
	typedef logic [7:0] evt_id_t;

	// Slave picked from the frame type
	typedef enum logic [1:0] {
		TGT_BASICS = 2'd0,
		TGT_GPIO   = 2'd1,
		TGT_NAK    = 2'd2
	} ice_target_e;

	// Master bus beat, 20 bits
	typedef struct packed {
		logic        valid;
		logic        last;
		ice_target_e target;
		evt_id_t     evt_id;
		ice_byte_t   data;
	} ma_bus_t;

	// Slave bus beat, 10 bits
	typedef struct packed {
		logic      valid;
		logic      last;
		ice_byte_t data;
	} sl_bus_t;

	// Frame parser states
	typedef enum logic [2:0] {
		IDLE,
		GET_ID,
		GET_LEN,
		PAYLOAD,
		WAIT_RESP,
		DRAIN
	} ctrl_state_e;

endpackage

`default_nettype wire

/* common/ice_settings.svh */
`ifndef ICE_SETTINGS_SVH
`define ICE_SETTINGS_SVH

// Clocks per UART bit
`define ICE_BAUD_DIV 8

// Response FIFO entries, power of two
`define ICE_FIFO_DEPTH 32

// Longest response frame in bytes
`define ICE_MAX_RESP 8

// Longest payload accepted from the host
`define ICE_MAX_LEN 4

// Slaves on the shared slave bus
`define ICE_NUM_SLAVES 2

// Version word returned by 'V'
`define ICE_VERSION 16'h0103

`endif

/* ice_bus_controller/ice_bus_controller.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ice_settings.svh"

module ice_bus_controller (
	input  wire                 clk,
	input  wire                 reset,
	input  wire                 rx_valid,
	input  ice_pkg::ice_byte_t  rx_data,
	output logic                tx_valid,
	output ice_pkg::ice_byte_t  tx_data,
	input  wire                 tx_empty,
	output ice_pkg::ma_bus_t    ma,
	input  wire [`ICE_NUM_SLAVES-1:0]  sl_arb_request,
	output logic [`ICE_NUM_SLAVES-1:0] sl_arb_grant,
	input  ice_pkg::sl_bus_t    sl [`ICE_NUM_SLAVES]
);

	localparam int CW = $clog2(`ICE_FIFO_DEPTH);

	ice_pkg::ctrl_state_e state;
	ice_pkg::ice_target_e tgt;
	ice_pkg::evt_id_t     id;
	ice_pkg::ice_byte_t   type_q;
	ice_pkg::ice_byte_t   remain;
	ice_pkg::sl_bus_t     sl_mux;
	logic fifo_room;
	logic resp_got, resp_done;
	logic first_beat, is_evt, beat_is_evt;

	slave_arbiter #(.N(`ICE_NUM_SLAVES)) arb0 (
		.clk(clk),
		.reset(reset),
		.request(sl_arb_request),
		.fifo_room(fifo_room),
		.grant(sl_arb_grant),
		.sl_in(sl),
		.sl(sl_mux)
	);

	// Frame type to slave
	function automatic ice_pkg::ice_target_e decode(input ice_pkg::ice_byte_t t);
		case (t)
			8'h56, 8'h53, 8'h47: decode = ice_pkg::TGT_BASICS;
			8'h67, 8'h65: decode = ice_pkg::TGT_GPIO;
			default: decode = ice_pkg::TGT_NAK;
		endcase
	endfunction

	function automatic ice_pkg::ma_bus_t beat(input logic last, input ice_pkg::ice_target_e t,
			input ice_pkg::evt_id_t i, input ice_pkg::ice_byte_t d);
		beat.valid = 1'b1;
		beat.last = last;
		beat.target = t;
		beat.evt_id = i;
		beat.data = d;
	endfunction

	// Unsolicited 'E' frames must not end the wait
	assign beat_is_evt = first_beat ? (sl_mux.data == 8'h45) : is_evt;
	assign resp_done = sl_mux.valid && sl_mux.last && !beat_is_evt;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ice_pkg::IDLE;
			tgt <= ice_pkg::TGT_NAK;
			ma <= '0;
			resp_got <= 1'b0;
			first_beat <= 1'b1;
			is_evt <= 1'b0;
		end else begin
			ma <= '0;
			if (sl_mux.valid) begin
				first_beat <= sl_mux.last;
				is_evt <= beat_is_evt;
			end
			if (resp_done)
				resp_got <= 1'b1;
			case (state)
				ice_pkg::IDLE: if (rx_valid) begin
					tgt <= decode(rx_data);
					type_q <= rx_data;
					resp_got <= 1'b0;
					state <= ice_pkg::GET_ID;
				end
				ice_pkg::GET_ID: if (rx_valid) begin
					id <= rx_data;
					state <= ice_pkg::GET_LEN;
				end
				ice_pkg::GET_LEN: if (rx_valid) begin
					remain <= rx_data;
					// Header beat carries the type byte
					if (tgt == ice_pkg::TGT_NAK || rx_data > 8'(`ICE_MAX_LEN)) begin
						ma <= beat(1'b1, ice_pkg::TGT_NAK, id, type_q);
						state <= (rx_data == 8'd0) ? ice_pkg::WAIT_RESP : ice_pkg::DRAIN;
					end else begin
						ma <= beat(rx_data == 8'd0, tgt, id, type_q);
						state <= (rx_data == 8'd0) ? ice_pkg::WAIT_RESP : ice_pkg::PAYLOAD;
					end
				end
				ice_pkg::PAYLOAD: if (rx_valid) begin
					ma <= beat(remain == 8'd1, tgt, id, rx_data);
					remain <= remain - 8'd1;
					if (remain == 8'd1)
						state <= ice_pkg::WAIT_RESP;
				end
				// Skip payload of a rejected frame
				ice_pkg::DRAIN: if (rx_valid) begin
					remain <= remain - 8'd1;
					if (remain == 8'd1)
						state <= ice_pkg::WAIT_RESP;
				end
				ice_pkg::WAIT_RESP: if (resp_got || resp_done)
					state <= ice_pkg::IDLE;
				default: state <= ice_pkg::IDLE;
			endcase
		end
	end

	// Response FIFO
	ice_pkg::ice_byte_t mem [`ICE_FIFO_DEPTH];
	logic [CW-1:0] wr_ptr, rd_ptr;
	logic [CW:0]   count;
	logic          fifo_rd;

	assign fifo_rd = tx_empty && !tx_valid && (count != '0);
	assign fifo_room = (count <= (CW + 1)'(`ICE_FIFO_DEPTH - `ICE_MAX_RESP));

	always_ff @(posedge clk) begin
		if (sl_mux.valid)
			mem[wr_ptr] <= sl_mux.data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			tx_valid <= 1'b0;
		end else begin
			tx_valid <= fifo_rd;
			if (sl_mux.valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (fifo_rd) begin
				tx_data <= mem[rd_ptr];
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + (CW + 1)'(sl_mux.valid) - (CW + 1)'(fifo_rd);
		end
	end

	// Arbiter room check keeps this from happening
	no_overflow: assert property (@(posedge clk) disable iff (reset)
		sl_mux.valid |-> (count != (CW + 1)'(`ICE_FIFO_DEPTH)));

endmodule

`default_nettype wire

/* ice_bus_controller/slave_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ice_settings.svh"

module slave_arbiter #(
	parameter int N = `ICE_NUM_SLAVES
) (
	input  wire                clk,
	input  wire                reset,
	input  wire [N-1:0]        request,
	input  wire                fifo_room,
	output logic [N-1:0]       grant,
	input  ice_pkg::sl_bus_t   sl_in [N],
	output ice_pkg::sl_bus_t   sl
);

	logic [N-1:0] pick;

	// Lowest requesting index wins
	always_comb begin
		pick = '0;
		for (int i = N - 1; i >= 0; i--) begin
			if (request[i])
				pick = N'(1) << i;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			grant <= '0;
		end else if (grant == '0) begin
			// Only when a whole response fits
			if (fifo_room)
				grant <= pick;
		end else if (sl.valid && sl.last) begin
			grant <= '0;
		end
	end

	// Granted slave owns the bus
	always_comb begin
		sl = '0;
		for (int i = 0; i < N; i++) begin
			if (grant[i])
				sl = sl_in[i];
		end
	end

	// Slaves keep requesting until their last beat
	grant_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0(grant) && ((grant & ~request) == '0));

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the ice_bus testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_ice_bus -o sim_tb_ice_bus

./obj_dir/sim_tb_ice_bus > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST PASS" sim.log; then
	exit 0
else
	exit 1
fi

/* source/basics_int.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ice_settings.svh"

module basics_int (
	input  wire               clk,
	input  wire               reset,
	input  ice_pkg::ma_bus_t  ma,
	output logic              request,
	input  wire               grant,
	output ice_pkg::sl_bus_t  sl
);

	localparam logic [15:0] VERSION = `ICE_VERSION;

	ice_pkg::ice_byte_t settings [4];
	ice_pkg::ice_byte_t type_q, p0, p1;
	ice_pkg::ice_byte_t cur_type, cur_p0, cur_p1;
	ice_pkg::ice_byte_t r_status, r_len, r_p0, r_p1;
	ice_pkg::evt_id_t   r_id;
	logic [1:0] cnt;
	logic [2:0] idx;
	logic mine, sl_last;

	assign mine = ma.valid &&
		(ma.target == ice_pkg::TGT_BASICS || ma.target == ice_pkg::TGT_NAK);

	// Last beat may carry the byte being decoded
	assign cur_type = (cnt == 2'd0) ? ma.data : type_q;
	assign cur_p0 = (cnt == 2'd1) ? ma.data : p0;
	assign cur_p1 = (cnt == 2'd2) ? ma.data : p1;

	always_ff @(posedge clk) begin
		if (reset) begin
			request <= 1'b0;
			cnt <= 2'd0;
			idx <= 3'd0;
			for (int i = 0; i < 4; i++)
				settings[i] <= '0;
		end else begin
			if (mine) begin
				cnt <= ma.last ? 2'd0 : cnt + 2'(cnt != 2'd3);
				case (cnt)
					2'd0: type_q <= ma.data;
					2'd1: p0 <= ma.data;
					2'd2: p1 <= ma.data;
					default: ;
				endcase
				if (ma.last) begin
					request <= 1'b1;
					r_id <= ma.evt_id;
					r_status <= 8'h41;
					r_len <= 8'd0;
					if (ma.target == ice_pkg::TGT_NAK) begin
						r_status <= 8'h4e;
					end else if (cur_type == 8'h56) begin
						// Version, high byte first
						r_len <= 8'd2;
						r_p0 <= VERSION[15:8];
						r_p1 <= VERSION[7:0];
					end else if (cur_type == 8'h53) begin
						settings[cur_p0[1:0]] <= cur_p1;
					end else begin
						r_len <= 8'd1;
						r_p0 <= settings[cur_p0[1:0]];
					end
				end
			end
			if (grant) begin
				idx <= idx + 3'd1;
				if (sl_last) begin
					idx <= 3'd0;
					request <= 1'b0;
				end
			end
		end
	end

	// Status, id, length, then payload
	assign sl_last = ({5'd0, idx} == r_len + 8'd2);

	always_comb begin
		sl.valid = grant;
		sl.last = grant && sl_last;
		case (idx)
			3'd0: sl.data = r_status;
			3'd1: sl.data = r_id;
			3'd2: sl.data = r_len;
			3'd3: sl.data = r_p0;
			default: sl.data = r_p1;
		endcase
	end

endmodule

`default_nettype wire

/* source/gpio_int.sv */
`timescale 1ns/10ps
`default_nettype none

module gpio_int (
	input  wire                clk,
	input  wire                reset,
	input  ice_pkg::ice_byte_t gpio_in,
	input  ice_pkg::ma_bus_t   ma,
	output logic               request,
	input  wire                grant,
	output ice_pkg::sl_bus_t   sl
);

	ice_pkg::ice_byte_t gpio_m, gpio_s, gpio_last;
	ice_pkg::ice_byte_t type_q, cur_type, r_len, r_p0, counter, len;
	ice_pkg::evt_id_t   r_id;
	logic cnt, rpt_en, cmd_pend, evt_pend;
	logic sel_evt, sel_evt_q, sl_last;
	logic [2:0] idx;

	assign cur_type = cnt ? type_q : ma.data;

	// Command first, event reports after
	assign sel_evt = (idx != 3'd0) ? sel_evt_q : !cmd_pend;
	assign len = sel_evt ? 8'd2 : r_len;
	assign sl_last = ({5'd0, idx} == len + 8'd2);
	assign request = cmd_pend || evt_pend;

	always_ff @(posedge clk) begin
		if (reset) begin
			gpio_m <= '0;
			gpio_s <= '0;
			gpio_last <= '0;
			rpt_en <= 1'b0;
			cmd_pend <= 1'b0;
			evt_pend <= 1'b0;
			counter <= '0;
			cnt <= 1'b0;
			idx <= 3'd0;
		end else begin
			gpio_m <= gpio_in;
			gpio_s <= gpio_m;
			if (ma.valid && ma.target == ice_pkg::TGT_GPIO) begin
				cnt <= !ma.last;
				if (!cnt)
					type_q <= ma.data;
				if (ma.last) begin
					cmd_pend <= 1'b1;
					r_id <= ma.evt_id;
					r_len <= 8'd0;
					if (cur_type == 8'h65) begin
						// Enable byte, payload beat
						rpt_en <= (ma.data != 8'd0);
					end else begin
						r_len <= 8'd1;
						r_p0 <= gpio_s;
					end
				end
			end
			if (grant) begin
				if (idx == 3'd0)
					sel_evt_q <= sel_evt;
				idx <= idx + 3'd1;
				if (sl_last) begin
					idx <= 3'd0;
					if (sel_evt) begin
						evt_pend <= 1'b0;
						// Wraps at 8 bits
						counter <= counter + 8'd1;
					end else begin
						cmd_pend <= 1'b0;
					end
				end
			end
			// Changes during a pending report merge into it
			if (gpio_s != gpio_last) begin
				gpio_last <= gpio_s;
				if (rpt_en)
					evt_pend <= 1'b1;
			end
		end
	end

	always_comb begin
		sl.valid = grant;
		sl.last = grant && sl_last;
		case (idx)
			3'd0: sl.data = sel_evt ? 8'h45 : 8'h41;
			3'd1: sl.data = sel_evt ? 8'h00 : r_id;
			3'd2: sl.data = len;
			3'd3: sl.data = sel_evt ? counter : r_p0;
			default: sl.data = gpio_last;
		endcase
	end

endmodule

`default_nettype wire

/* source/ice_bus.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ice_settings.svh"

module ice_bus (
	input  wire                clk,
	input  wire                reset,
	input  wire                uart_rx,
	output wire                uart_tx,
	input  ice_pkg::ice_byte_t gpio_in
);

	ice_pkg::ice_byte_t rx_data, tx_data;
	logic rx_valid, tx_valid, tx_empty;
	ice_pkg::ma_bus_t ma;
	ice_pkg::sl_bus_t sl_bus [`ICE_NUM_SLAVES];
	logic [`ICE_NUM_SLAVES-1:0] sl_arb_request, sl_arb_grant;

	// Host link
	uart u1 (
		.clk(clk),
		.reset(reset),
		.rx(uart_rx),
		.tx(uart_tx),
		.tx_valid(tx_valid),
		.tx_data(tx_data),
		.tx_empty(tx_empty),
		.rx_valid(rx_valid),
		.rx_data(rx_data)
	);

	ice_bus_controller ice1 (
		.clk(clk),
		.reset(reset),
		.rx_valid(rx_valid),
		.rx_data(rx_data),
		.tx_valid(tx_valid),
		.tx_data(tx_data),
		.tx_empty(tx_empty),
		.ma(ma),
		.sl_arb_request(sl_arb_request),
		.sl_arb_grant(sl_arb_grant),
		.sl(sl_bus)
	);

	// Slave 0, highest priority
	basics_int bi0 (
		.clk(clk),
		.reset(reset),
		.ma(ma),
		.request(sl_arb_request[0]),
		.grant(sl_arb_grant[0]),
		.sl(sl_bus[0])
	);

	gpio_int gi1 (
		.clk(clk),
		.reset(reset),
		.gpio_in(gpio_in),
		.ma(ma),
		.request(sl_arb_request[1]),
		.grant(sl_arb_grant[1]),
		.sl(sl_bus[1])
	);

endmodule

`default_nettype wire

/* source/uart.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ice_settings.svh"

module uart (
	input  wire              clk,
	input  wire              reset,
	input  wire              rx,
	output logic             tx,
	input  wire              tx_valid,
	input  ice_pkg::ice_byte_t tx_data,
	output logic             tx_empty,
	output logic             rx_valid,
	output ice_pkg::ice_byte_t rx_data
);

	localparam int DIV = `ICE_BAUD_DIV;

	// Receiver
	logic       rx_m, rx_s;
	logic       rx_busy;
	logic [3:0] rx_bit;
	logic [15:0] rx_cnt;
	ice_pkg::ice_byte_t rx_sh;

	always_ff @(posedge clk) begin
		if (reset) begin
			rx_m <= 1'b1;
			rx_s <= 1'b1;
			rx_busy <= 1'b0;
			rx_bit <= 4'd0;
			rx_cnt <= 16'd0;
			rx_valid <= 1'b0;
		end else begin
			// Two-flop synchronizer, line idles high
			rx_m <= rx;
			rx_s <= rx_m;
			rx_valid <= 1'b0;
			if (!rx_busy) begin
				// Start edge, first sample lands mid start bit
				if (!rx_s) begin
					rx_busy <= 1'b1;
					rx_bit <= 4'd0;
					rx_cnt <= 16'(DIV / 2 - 1);
				end
			end else if (rx_cnt != 16'd0) begin
				rx_cnt <= rx_cnt - 16'd1;
			end else begin
				rx_cnt <= 16'(DIV - 1);
				rx_bit <= rx_bit + 4'd1;
				if (rx_bit == 4'd0) begin
					// Glitch, not a real start bit
					if (rx_s)
						rx_busy <= 1'b0;
				end else if (rx_bit == 4'd9) begin
					// Bad stop bit drops the byte
					rx_busy <= 1'b0;
					rx_valid <= rx_s;
				end else begin
					rx_sh <= {rx_s, rx_sh[7:1]};
				end
			end
		end
	end

	assign rx_data = rx_sh;

	// Transmitter
	logic [9:0]  tx_sh;
	logic [3:0]  tx_bits;
	logic [15:0] tx_cnt;

	always_ff @(posedge clk) begin
		if (reset) begin
			tx_sh <= 10'h3ff;
			tx_bits <= 4'd0;
			tx_cnt <= 16'd0;
		end else if (tx_valid) begin
			// Stop, data LSB first, start
			tx_sh <= {1'b1, tx_data, 1'b0};
			tx_bits <= 4'd10;
			tx_cnt <= 16'(DIV - 1);
		end else if (tx_bits != 4'd0) begin
			if (tx_cnt != 16'd0) begin
				tx_cnt <= tx_cnt - 16'd1;
			end else begin
				tx_cnt <= 16'(DIV - 1);
				tx_sh <= {1'b1, tx_sh[9:1]};
				tx_bits <= tx_bits - 4'd1;
			end
		end
	end

	assign tx = tx_sh[0];
	assign tx_empty = (tx_bits == 4'd0);

	// Controller must wait for the shifter to drain
	tx_only_when_empty: assert property (@(posedge clk) disable iff (reset)
		tx_valid |-> tx_empty);

endmodule

`default_nettype wire

/* tb.f */
+incdir+common
common/ice_pkg.sv
source/uart.sv
ice_bus_controller/slave_arbiter.sv
ice_bus_controller/ice_bus_controller.sv
source/basics_int.sv
source/gpio_int.sv
source/ice_bus.sv
tests/tb_ice_bus.sv

/* tests/tb_ice_bus.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ice_settings.svh"

module tb_ice_bus;

	localparam int DIV = `ICE_BAUD_DIV;
	localparam logic [15:0] VERSION = `ICE_VERSION;
	// Wait limits in clocks
	localparam int RESP_WAIT = 2000;
	localparam int EVT_WAIT = 200;
	localparam int QUIET_WAIT = 400;

	// Frame and status characters
	localparam ice_pkg::ice_byte_t CH_ACK = "A";
	localparam ice_pkg::ice_byte_t CH_NAK = "N";
	localparam ice_pkg::ice_byte_t CH_EVT = "E";
	localparam ice_pkg::ice_byte_t CH_V = "V";
	localparam ice_pkg::ice_byte_t CH_S = "S";
	localparam ice_pkg::ice_byte_t CH_G = "G";
	localparam ice_pkg::ice_byte_t CH_GR = "g";
	localparam ice_pkg::ice_byte_t CH_EN = "e";
	localparam ice_pkg::ice_byte_t CH_BAD = "Z";

	logic clk = 1'b0;
	logic reset;
	logic uart_rx;
	wire  uart_tx;
	ice_pkg::ice_byte_t gpio_in;

	ice_pkg::ice_byte_t resp[$];
	bit resp_ok;
	int errors = 0;
	int checks = 0;
	int tests = 0;

	always #2 clk = ~clk;

	ice_bus u_dut (
		.clk(clk),
		.reset(reset),
		.uart_rx(uart_rx),
		.uart_tx(uart_tx),
		.gpio_in(gpio_in)
	);

	task automatic check_byte(input string name, input ice_pkg::ice_byte_t got,
			input ice_pkg::ice_byte_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t %s got %02h expected %02h", $time, name, got, exp);
		end
	endtask

	task automatic check_id(input string name, input ice_pkg::evt_id_t got,
			input ice_pkg::evt_id_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t %s got %02h expected %02h", $time, name, got, exp);
		end
	endtask

	// Host transmitter, start, LSB first, stop
	task automatic send_byte(input ice_pkg::ice_byte_t b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(negedge clk);
			uart_rx = bits[i];
			repeat (DIV - 1) @(negedge clk);
		end
	endtask

	task automatic send_frame(input ice_pkg::ice_byte_t t, input ice_pkg::evt_id_t id,
			input ice_pkg::ice_byte_t pl[$]);
		send_byte(t);
		send_byte(id);
		send_byte(8'(pl.size()));
		foreach (pl[i])
			send_byte(pl[i]);
	endtask

	// Host receiver, ok low on timeout or bad stop bit
	task automatic recv_byte(input int limit, output ice_pkg::ice_byte_t b, output bit ok);
		int n;
		ok = 1'b0;
		b = '0;
		n = 0;
		while (uart_tx !== 1'b0 && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (uart_tx !== 1'b0)
			return;
		// Middle of start bit
		repeat (DIV / 2) @(negedge clk);
		for (int i = 0; i < 8; i++) begin
			repeat (DIV) @(negedge clk);
			b[i] = uart_tx;
		end
		repeat (DIV) @(negedge clk);
		ok = (uart_tx === 1'b1);
	endtask

	// Header, then as many payload bytes as the length byte says
	task automatic recv_resp(input int first_limit);
		ice_pkg::ice_byte_t b;
		bit ok;
		int total;
		int i;
		resp.delete();
		resp_ok = 1'b0;
		total = 3;
		i = 0;
		while (i < total) begin
			recv_byte((i == 0) ? first_limit : 4 * DIV, b, ok);
			if (!ok) begin
				errors++;
				$display("no valid response byte %0d on uart_tx at %0t (timeout or bad stop bit)",
					i, $time);
				return;
			end
			resp.push_back(b);
			if (i == 2)
				total = 3 + ((int'(b) > `ICE_MAX_RESP - 3) ? `ICE_MAX_RESP - 3 : int'(b));
			i++;
		end
		resp_ok = 1'b1;
	endtask

	task automatic expect_resp(input ice_pkg::ice_byte_t status, input ice_pkg::evt_id_t id,
			input ice_pkg::ice_byte_t exp_pl[$]);
		if (!resp_ok)
			return;
		check_byte("status", resp[0], status);
		check_id("evt_id", ice_pkg::evt_id_t'(resp[1]), id);
		check_byte("length", resp[2], 8'(exp_pl.size()));
		for (int i = 0; i < exp_pl.size(); i++) begin
			if (3 + i < resp.size())
				check_byte("payload", resp[3 + i], exp_pl[i]);
		end
	endtask

	// Full duplex, the answer may start before the frame ends
	task automatic exchange(input ice_pkg::ice_byte_t t, input ice_pkg::evt_id_t id,
			input ice_pkg::ice_byte_t pl[$]);
		fork
			send_frame(t, id, pl);
			recv_resp(RESP_WAIT);
		join
	endtask

	task automatic wait_quiet(input int cycles);
		bit seen;
		seen = 1'b0;
		for (int n = 0; n < cycles; n++) begin
			@(negedge clk);
			if (uart_tx !== 1'b1)
				seen = 1'b1;
		end
		checks++;
		if (seen) begin
			errors++;
			$display("unexpected frame on uart_tx after reporting was disabled");
		end
	endtask

	task automatic report_test(input string name, input int e0);
		tests++;
		$display("test %s finished with %0d errors", name, errors - e0);
	endtask

	task automatic test_version();
		ice_pkg::evt_id_t id;
		ice_pkg::ice_byte_t pl[$];
		ice_pkg::ice_byte_t exp[$];
		int e0;
		e0 = errors;
		id = ice_pkg::evt_id_t'($urandom);
		exp.push_back(VERSION[15:8]);
		exp.push_back(VERSION[7:0]);
		exchange(CH_V, id, pl);
		expect_resp(CH_ACK, id, exp);
		report_test("version", e0);
	endtask

	task automatic test_settings();
		ice_pkg::ice_byte_t vals [4];
		ice_pkg::ice_byte_t pl[$];
		ice_pkg::ice_byte_t exp[$];
		ice_pkg::evt_id_t id;
		int e0;
		e0 = errors;
		// Read before any write
		id = ice_pkg::evt_id_t'($urandom);
		pl.push_back(8'($urandom % 4));
		exp.push_back(8'h00);
		exchange(CH_G, id, pl);
		expect_resp(CH_ACK, id, exp);
		for (int i = 0; i < 4; i++) begin
			vals[i] = 8'($urandom);
			id = ice_pkg::evt_id_t'($urandom);
			pl.delete();
			exp.delete();
			pl.push_back(8'(i));
			pl.push_back(vals[i]);
			exchange(CH_S, id, pl);
			expect_resp(CH_ACK, id, exp);
		end
		for (int i = 0; i < 4; i++) begin
			id = ice_pkg::evt_id_t'($urandom);
			pl.delete();
			exp.delete();
			pl.push_back(8'(i));
			exp.push_back(vals[i]);
			exchange(CH_G, id, pl);
			expect_resp(CH_ACK, id, exp);
		end
		report_test("settings", e0);
	endtask

	task automatic test_nak();
		ice_pkg::ice_byte_t pl[$];
		ice_pkg::ice_byte_t exp[$];
		ice_pkg::evt_id_t id;
		int e0;
		e0 = errors;
		id = ice_pkg::evt_id_t'($urandom);
		exchange(CH_BAD, id, pl);
		expect_resp(CH_NAK, id, exp);
		// One byte too long, payload still sent
		for (int i = 0; i < `ICE_MAX_LEN + 1; i++)
			pl.push_back(8'($urandom));
		id = ice_pkg::evt_id_t'($urandom);
		exchange(CH_V, id, pl);
		expect_resp(CH_NAK, id, exp);
		pl.delete();
		id = ice_pkg::evt_id_t'($urandom);
		exp.push_back(VERSION[15:8]);
		exp.push_back(VERSION[7:0]);
		exchange(CH_V, id, pl);
		expect_resp(CH_ACK, id, exp);
		report_test("nak", e0);
	endtask

	task automatic test_gpio_read();
		ice_pkg::ice_byte_t pl[$];
		ice_pkg::ice_byte_t exp[$];
		ice_pkg::evt_id_t id;
		int e0;
		e0 = errors;
		@(negedge clk);
		gpio_in = 8'($urandom);
		id = ice_pkg::evt_id_t'($urandom);
		exp.push_back(gpio_in);
		exchange(CH_GR, id, pl);
		expect_resp(CH_ACK, id, exp);
		report_test("gpio_read", e0);
	endtask

	task automatic test_events();
		ice_pkg::ice_byte_t pl[$];
		ice_pkg::ice_byte_t exp[$];
		ice_pkg::evt_id_t id;
		int e0;
		e0 = errors;
		id = ice_pkg::evt_id_t'($urandom);
		pl.push_back(8'($urandom % 255) + 8'd1);
		exchange(CH_EN, id, pl);
		expect_resp(CH_ACK, id, exp);
		for (int k = 0; k < 3; k++) begin
			// Always a real change
			@(negedge clk);
			gpio_in = gpio_in ^ (8'($urandom % 255) + 8'd1);
			recv_resp(EVT_WAIT);
			exp.delete();
			exp.push_back(8'(k));
			exp.push_back(gpio_in);
			expect_resp(CH_EVT, 8'h00, exp);
			repeat (DIV) @(negedge clk);
		end
		// Reporting off
		id = ice_pkg::evt_id_t'($urandom);
		pl.delete();
		exp.delete();
		pl.push_back(8'h00);
		exchange(CH_EN, id, pl);
		expect_resp(CH_ACK, id, exp);
		@(negedge clk);
		gpio_in = gpio_in ^ 8'h5a;
		wait_quiet(QUIET_WAIT);
		report_test("events", e0);
	endtask

	task automatic test_back_to_back();
		ice_pkg::ice_byte_t none[$];
		ice_pkg::ice_byte_t exp[$];
		ice_pkg::evt_id_t id0, id1;
		int e0;
		e0 = errors;
		id0 = ice_pkg::evt_id_t'($urandom);
		id1 = ice_pkg::evt_id_t'($urandom);
		fork
			begin
				send_frame(CH_GR, id0, none);
				send_frame(CH_V, id1, none);
			end
			begin
				recv_resp(RESP_WAIT);
				exp.push_back(gpio_in);
				expect_resp(CH_ACK, id0, exp);
				recv_resp(RESP_WAIT);
				exp.delete();
				exp.push_back(VERSION[15:8]);
				exp.push_back(VERSION[7:0]);
				expect_resp(CH_ACK, id1, exp);
			end
		join
		report_test("back_to_back", e0);
	endtask

	initial begin
		void'($urandom(32'hadcd));
		reset = 1'b1;
		uart_rx = 1'b1;
		gpio_in = 8'h00;
		repeat (16) @(negedge clk);
		reset = 1'b0;
		repeat (4) @(negedge clk);
		test_version();
		test_settings();
		test_nak();
		test_gpio_read();
		test_events();
		test_back_to_back();
		$display("tests %0d checks %0d errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire
